//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb
FILELIST  ?= tb.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Simulation completed successfully

SOURCES := $(filter %.sv %.v,$(shell cat $(FILELIST)))
SIM     := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM) 2>&1)"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)

//--- aluCore.sv
`timescale 1ns/1ps

module aluCore (
    aluCoreIf.core bus
);
    import aluPkg::*;

    // Width follows the interface instance
    localparam int width = $bits(bus.a);
    localparam int msb = width - 1;

    // One extra bit on top for carry out or borrow
    logic [width:0]   wide;
    logic [width-1:0] res;
    logic             carry;
    logic             overflow;

    ////////////////////////////////////////
    // Operation select
    ////////////////////////////////////////

    always_comb begin
        wide     = '0;
        carry    = 1'b0;
        overflow = 1'b0;
        case (bus.opCode)
            opAdd: begin
                wide     = {1'b0, bus.a} + {1'b0, bus.b};
                carry    = wide[width];
                // Like signs in, opposite sign out
                overflow = (bus.a[msb] == bus.b[msb]) && (wide[msb] != bus.a[msb]);
            end
            opSub: begin
                wide     = {1'b0, bus.a} - {1'b0, bus.b};
                // Top bit set when b is larger than a
                carry    = wide[width];
                // Unlike signs in, result sign differs from a
                overflow = (bus.a[msb] != bus.b[msb]) && (wide[msb] != bus.a[msb]);
            end
            // Logic ops leave C and V at zero
            opOr: begin
                wide = {1'b0, bus.a | bus.b};
            end
            opAnd: begin
                wide = {1'b0, bus.a & bus.b};
            end
            default: begin
                wide = '0;
            end
        endcase
        res = wide[width-1:0];
    end

    ////////////////////////////////////////
    // Flags
    ////////////////////////////////////////

    always_comb begin
        bus.result       = res;
        bus.flags        = '0;
        // Sign bit of the result
        bus.flags[flagN] = res[msb];
        bus.flags[flagZ] = (res == '0);
        bus.flags[flagC] = carry;
        bus.flags[flagV] = overflow;
    end

endmodule

//--- aluCoreIf.sv
`timescale 1ns/1ps

interface aluCoreIf #(
    parameter int dataWidth = 16
);
    import aluPkg::*;

    // Registered operands and opcode toward the core
    logic [dataWidth-1:0] a;
    logic [dataWidth-1:0] b;
    aluOp                 opCode;

    // Unregistered core outputs back to the datapath
    logic [dataWidth-1:0] result;
    aluFlags              flags;

    modport datapath (output a, b, opCode, input result, flags);
    modport core (input a, b, opCode, output result, flags);

endinterface

//--- aluDatapath.sv
`timescale 1ns/1ps

module aluDatapath #(
    parameter int dataWidth = 16
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 loadOpA,
    input  logic                 loadOpB,
    input  logic                 loadOpCode,
    input  logic                 updateRes,
    input  aluPkg::dataWord      dataIn,
    output logic [dataWidth-1:0] result,
    output aluPkg::aluFlags      flags,
    aluCoreIf.datapath           alu
);
    import aluPkg::*;

    logic [dataWidth-1:0] opA;
    logic [dataWidth-1:0] opB;
    aluOp                 opCode;

    // Display shows at most maxDataWidth bits
    if (dataWidth > maxDataWidth) begin : gWidthCheck
        $error("aluDatapath dataWidth %0d is above %0d", dataWidth, maxDataWidth);
    end

    ////////////////////////////////////////
    // Operand and opcode registers
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            opA    <= '0;
            opB    <= '0;
            opCode <= opAdd;
        end else begin
            // Operands through the operand view
            if (loadOpA)
                opA <= dataIn.operand[dataWidth-1:0];
            if (loadOpB)
                opB <= dataIn.operand[dataWidth-1:0];
            // Opcode through the command view
            if (loadOpCode)
                opCode <= dataIn.command.opCode;
        end
    end

    // To the core
    assign alu.a      = opA;
    assign alu.b      = opB;
    assign alu.opCode = opCode;

    ////////////////////////////////////////
    // Result and flag registers
    ////////////////////////////////////////

    // Samples core output from the old operands at the updateRes edge
    always_ff @(posedge clk) begin
        if (reset) begin
            result <= '0;
            flags  <= '0;
        end else if (updateRes) begin
            result <= alu.result;
            flags  <= alu.flags;
        end
    end

endmodule

//--- aluDisplayTop.sv
`timescale 1ns/1ps

module aluDisplayTop #(
    parameter int dataWidth   = 16,
    parameter int scanDivBits = 2
) (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              loadOpA,
    input  logic                              loadOpB,
    input  logic                              loadOpCode,
    input  logic                              updateRes,
    input  logic [dataWidth-1:0]              dataIn,
    output logic [dataWidth-1:0]              result,
    output aluPkg::aluFlags                   flags,
    output displayPkg::segPattern             segments,
    output logic [displayPkg::anodeCount-1:0] anodes
);
    import aluPkg::*;

    // Zero-extended bus word
    dataWord busWord;

    assign busWord.operand = maxDataWidth'(dataIn);

    // Datapath to core link
    aluCoreIf #(.dataWidth(dataWidth)) coreBus ();

    aluCore core0 (
        .bus        (coreBus.core)
    );

    aluDatapath #(.dataWidth(dataWidth)) datapath0 (
        .clk        (clk),
        .reset      (reset),
        .loadOpA    (loadOpA),
        .loadOpB    (loadOpB),
        .loadOpCode (loadOpCode),
        .updateRes  (updateRes),
        .dataIn     (busWord),
        .result     (result),
        .flags      (flags),
        .alu        (coreBus.datapath)
    );

    // Display scans the registered result
    segmentDriver #(
        .dataWidth   (dataWidth),
        .scanDivBits (scanDivBits)
    ) display0 (
        .clk        (clk),
        .reset      (reset),
        .value      (result),
        .segments   (segments),
        .anodes     (anodes)
    );

endmodule

//--- aluDisplayTop_props.sv
`timescale 1ns/1ps

module aluDisplayTopProps #(
    parameter int dataWidth = 16
) (
    input logic                              clk,
    input logic                              reset,
    input logic                              updateRes,
    input logic [dataWidth-1:0]              result,
    input logic [displayPkg::anodeCount-1:0] anodes
);
    import displayPkg::*;

    localparam int digitCount = dataWidth / 4;
    // Ones on the digits that the scan visits
    localparam logic [anodeCount-1:0] usedMask = anodeCount'((1 << digitCount) - 1);

    ////////////////////////////////////////
    // Display scan
    ////////////////////////////////////////

    // Exactly one used digit lit
    anodeOneCold: assert property (@(posedge clk) disable iff (reset)
        $onehot(~anodes & usedMask))
        else $error("anodes not one-cold within used digits: %b", anodes);

    // Digits above the result width stay dark
    unusedDark: assert property (@(posedge clk) disable iff (reset)
        (anodes | usedMask) == '1)
        else $error("unused anode driven low: %b", anodes);

    ////////////////////////////////////////
    // Result register
    ////////////////////////////////////////

    // Only an updateRes edge may move the result
    resultHold: assert property (@(posedge clk) disable iff (reset)
        (!$past(updateRes) && !$past(reset)) |-> $stable(result))
        else $error("result changed without updateRes");

endmodule

bind aluDisplayTop aluDisplayTopProps #(.dataWidth(dataWidth)) props0 (
    .clk       (clk),
    .reset     (reset),
    .updateRes (updateRes),
    .result    (result),
    .anodes    (anodes)
);

//--- aluPkg.sv
package aluPkg;

    // Two-bit operation code, taken from the low bits of dataIn
    typedef enum logic [1:0] {
        opAdd = 2'b00,
        opSub = 2'b01,
        opOr  = 2'b10,
        opAnd = 2'b11
    } aluOp;

    // Flag word layout {N, Z, C, V}
    localparam int flagN = 3;
    localparam int flagZ = 2;
    localparam int flagC = 1;
    localparam int flagV = 0;

    typedef logic [3:0] aluFlags;

    // Widest operand that eight hex digits can show
    localparam int maxDataWidth = 32;

    // Command view of the bus word
    typedef struct packed {
        logic [maxDataWidth-3:0] spare;
        aluOp                    opCode;
    } aluCommand;

    // One bus word read as operand or as command depending on the strobe
    typedef union packed {
        logic [maxDataWidth-1:0] operand;
        aluCommand               command;
    } dataWord;

endpackage

//--- displayPkg.sv
package displayPkg;

    // Segments {a, b, c, d, e, f, g}
    // Low lights a segment on the common-anode board
    typedef logic [6:0] segPattern;

    // Digits on the board
    localparam int anodeCount = 8;

    // Hex nibble to active-low glyph
    function automatic segPattern hexGlyph(input logic [3:0] nibble);
        segPattern glyph;
        case (nibble)
            4'h0: glyph = 7'b0000001;
            4'h1: glyph = 7'b1001111;
            4'h2: glyph = 7'b0010010;
            4'h3: glyph = 7'b0000110;
            4'h4: glyph = 7'b1001100;
            4'h5: glyph = 7'b0100100;
            4'h6: glyph = 7'b0100000;
            4'h7: glyph = 7'b0001111;
            4'h8: glyph = 7'b0000000;
            4'h9: glyph = 7'b0000100;
            // Letters A to F with b and d in lower case
            4'hA: glyph = 7'b0001000;
            4'hB: glyph = 7'b1100000;
            4'hC: glyph = 7'b0110001;
            4'hD: glyph = 7'b1000010;
            4'hE: glyph = 7'b0110000;
            default: glyph = 7'b0111000;
        endcase
        return glyph;
    endfunction

endpackage

//--- segmentDriver.sv
`timescale 1ns/1ps

module segmentDriver #(
    parameter int dataWidth   = 16,
    parameter int scanDivBits = 2
) (
    input  logic                              clk,
    input  logic                              reset,
    input  logic [dataWidth-1:0]              value,
    output displayPkg::segPattern             segments,
    output logic [displayPkg::anodeCount-1:0] anodes
);
    import displayPkg::*;

    localparam int idxBits = $clog2(anodeCount);
    // Digits actually in use
    localparam int digitCount = dataWidth / 4;
    localparam logic [idxBits-1:0] lastDigit = idxBits'(digitCount - 1);

    logic [scanDivBits-1:0]  prescale;
    logic [idxBits-1:0]      digitIdx;
    logic [4*anodeCount-1:0] padded;
    logic [3:0]              nibble;

    ////////////////////////////////////////
    // Scan counters
    ////////////////////////////////////////

    // Free-running prescaler
    always_ff @(posedge clk) begin
        if (reset)
            prescale <= '0;
        else
            prescale <= prescale + 1'b1;
    end

    // Digit advances when prescaler wraps
    always_ff @(posedge clk) begin
        if (reset) begin
            digitIdx <= '0;
        end else if (prescale == '1) begin
            if (digitIdx == lastDigit)
                digitIdx <= '0;
            else
                digitIdx <= digitIdx + 1'b1;
        end
    end

    ////////////////////////////////////////
    // Digit select and glyph
    ////////////////////////////////////////

    always_comb begin
        // Pad to eight nibbles
        padded                  = '0;
        padded[dataWidth-1:0]   = value;
        nibble                  = padded[{digitIdx, 2'b00} +: 4];
        segments                = hexGlyph(nibble);
    end

    // One-cold anodes
    always_comb begin
        for (int k = 0; k < anodeCount; k++) begin
            // Digits above the value width stay dark
            anodes[k] = !((k < digitCount) && (digitIdx == idxBits'(k)));
        end
    end

endmodule

//--- tb.f
aluPkg.sv
displayPkg.sv
aluCoreIf.sv
aluCore.sv
aluDatapath.sv
segmentDriver.sv
aluDisplayTop.sv
aluDisplayTop_props.sv
tb.sv

//--- tb.sv
`timescale 1ns/1ps

module tb;
    import aluPkg::*;
    import displayPkg::*;

    localparam int dataWidth = 16;
    localparam int digitCount = dataWidth / 4;
    localparam int tableRows = 11;
    localparam int randomRows = 40;
    localparam int waitLimit = 200;

    typedef struct packed {
        logic [15:0] a;
        logic [15:0] b;
        aluOp        op;
        logic [15:0] res;
        aluFlags     flags;
    } tableRow;

    logic                  clk = 1'b0;
    logic                  reset;
    logic                  loadOpA;
    logic                  loadOpB;
    logic                  loadOpCode;
    logic                  updateRes;
    logic [dataWidth-1:0]  dataIn;
    logic [dataWidth-1:0]  result;
    aluFlags               flags;
    segPattern             segments;
    logic [anodeCount-1:0] anodes;
    logic [15:0]           lfsr = 16'd90;

    // Active-low abcdefg glyphs for 0 to F
    logic [6:0] glyphTable [16] = '{7'h01, 7'h4F, 7'h12, 7'h06, 7'h4C, 7'h24, 7'h20, 7'h0F,
                                    7'h00, 7'h04, 7'h08, 7'h60, 7'h31, 7'h42, 7'h30, 7'h38};

    // Hand-derived edge cases with flags as {N, Z, C, V}
    tableRow rows [tableRows] = '{
        '{16'h7FFF, 16'h0001, opAdd, 16'h8000, 4'b1001},
        '{16'hFFFF, 16'h0001, opAdd, 16'h0000, 4'b0110},
        '{16'h8000, 16'h8000, opAdd, 16'h0000, 4'b0111},
        '{16'h1234, 16'h4321, opAdd, 16'h5555, 4'b0000},
        '{16'h0000, 16'h0001, opSub, 16'hFFFF, 4'b1010},
        '{16'h8000, 16'h0001, opSub, 16'h7FFF, 4'b0001},
        '{16'h1234, 16'h1234, opSub, 16'h0000, 4'b0100},
        '{16'hF0F0, 16'h0F0F, opOr,  16'hFFFF, 4'b1000},
        '{16'h0000, 16'h0000, opOr,  16'h0000, 4'b0100},
        '{16'hF0F0, 16'h0F0F, opAnd, 16'h0000, 4'b0100},
        '{16'h8001, 16'hFFFF, opAnd, 16'h8001, 4'b1000}
    };

    aluDisplayTop #(.dataWidth(dataWidth), .scanDivBits(2)) dut0 (
        .clk(clk), .reset(reset), .loadOpA(loadOpA), .loadOpB(loadOpB),
        .loadOpCode(loadOpCode), .updateRes(updateRes), .dataIn(dataIn),
        .result(result), .flags(flags), .segments(segments), .anodes(anodes)
    );

    always #20 clk = ~clk;

    task automatic checkEqual(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, actual, expected);
            $display("Simulation failed");
            $fatal(1, "stopping after first mismatch");
        end
    endtask

    // Galois LFSR with polynomial x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsrStep(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // One step per bit taken
    task automatic drawBits(input int n, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsrStep(lfsr);
            bits = {bits[30:0], lfsr[0]};
        end
    endtask

    // Reference from the flag rules returning {result, N, Z, C, V}
    function automatic logic [19:0] expectedOutput(input logic [15:0] a,
                                                   input logic [15:0] b, input aluOp op);
        int full;
        int sFull;
        logic [15:0] r;
        logic c;
        logic v;
        c = 1'b0;
        v = 1'b0;
        case (op)
            opAdd: begin
                full  = int'(a) + int'(b);
                sFull = int'($signed(a)) + int'($signed(b));
                c     = full > 65535;
                v     = (sFull > 32767) || (sFull < -32768);
                r     = full[15:0];
            end
            opSub: begin
                full  = int'(a) - int'(b);
                sFull = int'($signed(a)) - int'($signed(b));
                // Borrow when b exceeds a
                c     = a < b;
                v     = (sFull > 32767) || (sFull < -32768);
                r     = full[15:0];
            end
            opOr:    r = a | b;
            default: r = a & b;
        endcase
        return {r, r[15], r == 16'h0000, c, v};
    endfunction

    // Load A, B, opcode, then optionally capture with a stray A reload alongside
    task automatic applyOp(input logic [15:0] a, input logic [15:0] b, input aluOp op,
                           input logic doUpdate);
        @(negedge clk);
        dataIn  = a;
        loadOpA = 1'b1;
        @(negedge clk);
        loadOpA = 1'b0;
        dataIn  = b;
        loadOpB = 1'b1;
        @(negedge clk);
        loadOpB    = 1'b0;
        dataIn     = {{(dataWidth-2){1'b0}}, op};
        loadOpCode = 1'b1;
        @(negedge clk);
        loadOpCode = 1'b0;
        dataIn     = ~a;
        loadOpA    = doUpdate;
        updateRes  = doUpdate;
        @(negedge clk);
        loadOpA   = 1'b0;
        updateRes = 1'b0;
    endtask

    task automatic waitAnodeLow(input int k);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (anodes[k] !== 1'b0) begin
            if (cycles == waitLimit) begin
                $display("Timeout: anode %0d never went low", k);
                $display("Simulation failed");
                $fatal(1, "display scan stalled");
            end
            cycles++;
            @(negedge clk);
        end
    endtask

    // Walk each used digit and compare its glyph
    task automatic checkDisplay(input logic [15:0] expRes);
        for (int k = 0; k < digitCount; k++) begin
            waitAnodeLow(k);
            checkEqual(segments, glyphTable[expRes[4*k +: 4]], $sformatf("glyph digit %0d", k));
            checkEqual(anodes[7:4], 4'hF, "unused anodes");
        end
    endtask

    initial begin
        logic [31:0] ra;
        logic [31:0] rb;
        logic [31:0] rop;
        logic [19:0] modelOut;
        reset      = 1'b1;
        loadOpA    = 1'b0;
        loadOpB    = 1'b0;
        loadOpCode = 1'b0;
        updateRes  = 1'b0;
        dataIn     = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // Reset state
        checkEqual(result, 0, "result after reset");
        checkEqual(flags, 0, "flags after reset");
        checkEqual(anodes[0], 0, "anode 0 after reset");
        checkEqual(segments, glyphTable[0], "zero glyph after reset");

        ////////////////////////////////////////
        // Table and random rows
        ////////////////////////////////////////
        for (int i = 0; i < tableRows; i++) begin
            applyOp(rows[i].a, rows[i].b, rows[i].op, 1'b1);
            checkEqual(result, rows[i].res, $sformatf("table row %0d result", i));
            checkEqual(flags, rows[i].flags, $sformatf("table row %0d flags", i));
        end
        for (int i = 0; i < randomRows; i++) begin
            drawBits(16, ra);
            drawBits(16, rb);
            drawBits(2, rop);
            modelOut = expectedOutput(ra[15:0], rb[15:0], aluOp'(rop[1:0]));
            applyOp(ra[15:0], rb[15:0], aluOp'(rop[1:0]), 1'b1);
            checkEqual(result, modelOut[19:4], $sformatf("random row %0d result", i));
            checkEqual(flags, modelOut[3:0], $sformatf("random row %0d flags", i));
        end

        // Reload without capture, then capture alone
        applyOp(16'h0003, 16'h0005, opSub, 1'b0);
        checkEqual(result, modelOut[19:4], "result held over reload");
        checkEqual(flags, modelOut[3:0], "flags held over reload");
        @(negedge clk);
        updateRes = 1'b1;
        @(negedge clk);
        updateRes = 1'b0;
        checkEqual(result, 16'hFFFE, "late capture result");
        checkEqual(flags, 4'b1010, "late capture flags");

        // Distinct nibbles for the scan
        applyOp(16'hA0B0, 16'h0C0D, opAdd, 1'b1);
        checkEqual(result, 16'hACBD, "display value");
        checkEqual(flags, 4'b1000, "display value flags");
        checkDisplay(16'hACBD);

        $display("Simulation completed successfully");
        $finish;
    end

endmodule
